// ==== include/az_switch_codes.svh ====
// switch drive codes for the auto-zero front end, included by the sequencer and the bench
`ifndef AZ_SWITCH_CODES_SVH
`define AZ_SWITCH_CODES_SVH

// precharge switch codes
// boot guards the signal from azmux charge injection
`define AZ_SW_PC_BOOT      2'b00
`define AZ_SW_PC_SIGNAL    2'b01

// default azmux codes, hi is the precharge output, lo is the input low
`define AZ_AZMUX_HI_DEF    4'b0011
`define AZ_AZMUX_LO_DEF    4'b0110

`endif

// ==== src/az_pkg.sv ====
// shared widths and packed structs for the auto-zero acquisition design, imported by every block
`default_nettype none

package az_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // adc reading width
  localparam int AZ_ADC_W   = 24;
  // default precharge count width, default of CountWidth
  localparam int AZ_COUNT_W = 24;
  // switch field widths
  localparam int AZ_MUX_W   = 4;
  localparam int AZ_PC_W    = 2;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////

  // runtime configuration, 34 bits
  typedef struct packed {
    logic [AZ_MUX_W-1:0]   azmux_lo;
    logic [AZ_MUX_W-1:0]   azmux_hi;
    // precharge setting that passes the signal
    logic [AZ_PC_W-1:0]    sw_pc_hi;
    // length of every settle phase
    logic [AZ_COUNT_W-1:0] precharge_count;
  } az_cfg_t;

  // switch drive, 6 bits
  typedef struct packed {
    logic [AZ_MUX_W-1:0] azmux;
    logic [AZ_PC_W-1:0]  sw_pc;
  } az_switch_t;

  // status word, bit 0 is the hi/lo tag of the last sample
  typedef struct packed {
    logic reserved;
    logic prim_w4;
    logic hi;
  } az_status_t;

  // latched reading pair with the sign of hi minus lo, 49 bits
  typedef struct packed {
    logic [AZ_ADC_W-1:0] hi;
    logic [AZ_ADC_W-1:0] lo;
    logic                sign;
  } az_result_t;

endpackage

`default_nettype wire

// ==== src/az_phase_timer.sv ====
// settle phase timer, loaded by the sequencer on entry to each settle state
`timescale 1ns/1ps
`default_nettype none

module az_phase_timer #(
  parameter int CountWidth = az_pkg::AZ_COUNT_W
) (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  // one-cycle load pulse
  input  wire logic                  load_i,
  input  wire logic [CountWidth-1:0] count_i,
  // high while the count sits at zero
  output logic                       done_o
);

  logic [CountWidth-1:0] count_q;
  logic [CountWidth-1:0] count_next;

  // next count, load wins, otherwise step down and hold at zero
  always_comb
  begin
    if (load_i)
      count_next = count_i;
    else if (count_q != '0)
      count_next = count_q - 1'b1;
    else
      count_next = count_q;
  end

  // done is taken from the next count so it rises count+1 cycles after load
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      count_q <= '0;
      // idle timer reads as done
      done_o  <= 1'b1;
    end
    else
    begin
      count_q <= count_next;
      done_o  <= (count_next == '0);
    end
  end

endmodule

`default_nettype wire

// ==== src/az_sequencer.sv ====
// auto-zero cycle FSM, drives the switches, the adc reset and the capture strobe
`timescale 1ns/1ps
`default_nettype none

`include "az_switch_codes.svh"

module az_sequencer #(
  parameter int CountWidth = az_pkg::AZ_COUNT_W
) (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  // level, low holds the cycle in idle
  input  wire logic                  arm_i,
  input  wire az_pkg::az_cfg_t       cfg_i,
  input  wire logic                  timer_done_i,
  input  wire logic                  adc_measure_valid_i,
  output logic                       timer_load_o,
  output logic [CountWidth-1:0]      timer_count_o,
  output az_pkg::az_switch_t         switch_o,
  // adc held in reset while low
  output logic                       adc_reset_no,
  output az_pkg::az_status_t         status_o,
  // combinational, high in the cycle the adc valid is accepted
  output logic                       sample_strobe_o,
  output logic                       sample_hi_o
);

  import az_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_BOOT_GUARD,
    ST_HI_SETTLE,
    ST_SIG_SETTLE,
    ST_HI_MEASURE,
    ST_BOOT_RETURN,
    ST_LO_SETTLE,
    ST_LO_MEASURE
  } state_t;

  state_t     state_q;
  logic       load_q;
  logic       settled;
  logic       measuring;
  logic       accept;
  az_switch_t idle_sw;

  // idle drive, precharge on boot and azmux on lo
  assign idle_sw = '{azmux: cfg_i.azmux_lo, sw_pc: `AZ_SW_PC_BOOT};

  // every phase has the same length
  assign timer_count_o = CountWidth'(cfg_i.precharge_count);
  assign timer_load_o  = load_q;

  // done is stale in the load cycle, the timer only sees the load at the edge
  assign settled = timer_done_i && !load_q;

  assign measuring = (state_q == ST_HI_MEASURE) || (state_q == ST_LO_MEASURE);

  // valid only counts while the adc is released and we are waiting for it
  assign accept = arm_i && measuring && adc_reset_no && adc_measure_valid_i;

  assign sample_strobe_o = accept;
  assign sample_hi_o     = (state_q == ST_HI_MEASURE);

  //////////////////////////////////////////////////////////////////////
  // state, switch and adc reset registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // load is a single pulse on entry to a settle state
    load_q <= 1'b0;

    if (!reset_n || !arm_i)
    begin
      state_q      <= ST_IDLE;
      switch_o     <= idle_sw;
      adc_reset_no <= 1'b0;
      status_o     <= '0;
    end
    else
    begin
      case (state_q)

        // armed, guard the signal before anything moves
        ST_IDLE:
        begin
          state_q        <= ST_BOOT_GUARD;
          switch_o.sw_pc <= `AZ_SW_PC_BOOT;
          load_q         <= 1'b1;
        end

        ST_BOOT_GUARD:
          if (settled)
          begin
            // azmux to hi, precharge still on boot
            state_q        <= ST_HI_SETTLE;
            switch_o.azmux <= cfg_i.azmux_hi;
            load_q         <= 1'b1;
          end

        ST_HI_SETTLE:
          if (settled)
          begin
            // precharge from boot to signal
            state_q        <= ST_SIG_SETTLE;
            switch_o.sw_pc <= cfg_i.sw_pc_hi;
            load_q         <= 1'b1;
          end

        ST_SIG_SETTLE:
          if (settled)
          begin
            // release adc for the hi reading
            state_q      <= ST_HI_MEASURE;
            adc_reset_no <= 1'b1;
          end

        ST_HI_MEASURE:
          if (accept)
          begin
            state_q        <= ST_BOOT_RETURN;
            adc_reset_no   <= 1'b0;
            status_o       <= '{reserved: 1'b0, prim_w4: 1'b0, hi: 1'b1};
            // back to boot to protect the signal again
            switch_o.sw_pc <= `AZ_SW_PC_BOOT;
            load_q         <= 1'b1;
          end

        ST_BOOT_RETURN:
          if (settled)
          begin
            // azmux to lo
            state_q        <= ST_LO_SETTLE;
            switch_o.azmux <= cfg_i.azmux_lo;
            load_q         <= 1'b1;
          end

        ST_LO_SETTLE:
          if (settled)
          begin
            // release adc for the lo reading
            state_q      <= ST_LO_MEASURE;
            adc_reset_no <= 1'b1;
          end

        ST_LO_MEASURE:
          if (accept)
          begin
            // cycle restarts at hi, precharge already on boot
            state_q        <= ST_HI_SETTLE;
            adc_reset_no   <= 1'b0;
            status_o       <= '0;
            switch_o.azmux <= cfg_i.azmux_hi;
            load_q         <= 1'b1;
          end

        default:
          state_q <= ST_IDLE;

      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/az_sample_capture.sv ====
// latches tagged adc readings and emits the auto-zeroed hi minus lo result after each lo sample
`timescale 1ns/1ps
`default_nettype none

module az_sample_capture (
  input  wire logic                         clk,
  input  wire logic                         reset_n,
  // one cycle, adc_data_i is read in the same cycle
  input  wire logic                         sample_strobe_i,
  input  wire logic                         sample_hi_i,
  input  wire logic [az_pkg::AZ_ADC_W-1:0]  adc_data_i,
  output logic                              result_valid_o,
  output az_pkg::az_result_t                result_o,
  output logic signed [az_pkg::AZ_ADC_W:0]  result_diff_o
);

  import az_pkg::*;

  logic [AZ_ADC_W-1:0]      hi_q;
  logic                     have_hi_q;
  logic                     lo_strobe;
  logic signed [AZ_ADC_W:0] diff;

  // readings are unsigned codes, zero extend before subtracting
  assign diff = $signed({1'b0, hi_q}) - $signed({1'b0, adc_data_i});

  // a lo reading only makes a result once a hi reading is held
  assign lo_strobe = sample_strobe_i && !sample_hi_i && have_hi_q;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      have_hi_q      <= 1'b0;
      result_valid_o <= 1'b0;
    end
    else
    begin
      if (sample_strobe_i && sample_hi_i)
        have_hi_q <= 1'b1;
      // single cycle pulse, nothing downstream can stall it
      result_valid_o <= lo_strobe;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    // latest hi reading, waits for its lo partner
    if (sample_strobe_i && sample_hi_i)
      hi_q <= adc_data_i;

    // result holds until the next lo sample
    if (lo_strobe)
    begin
      result_o      <= '{hi: hi_q, lo: adc_data_i, sign: diff[AZ_ADC_W]};
      result_diff_o <= diff;
    end
  end

endmodule

`default_nettype wire

// ==== src/az_acquisition_top.sv ====
// acquisition top level, wires timer, sequencer and capture and drives the monitor pins
`timescale 1ns/1ps
`default_nettype none

module az_acquisition_top #(
  parameter int CountWidth = az_pkg::AZ_COUNT_W
) (
  input  wire logic                         clk,
  input  wire logic                         reset_n,
  input  wire az_pkg::az_cfg_t              cfg_i,
  input  wire logic                         arm_i,
  input  wire logic                         adc_measure_valid_i,
  input  wire logic [az_pkg::AZ_ADC_W-1:0]  adc_data_i,
  output logic                              adc_reset_no,
  output az_pkg::az_switch_t                switch_o,
  output az_pkg::az_status_t                status_o,
  output logic                              result_valid_o,
  output logic signed [az_pkg::AZ_ADC_W:0]  result_diff_o,
  output az_pkg::az_result_t                result_o,
  output logic [1:0]                        monitor_o
);

  logic                  timer_load;
  logic [CountWidth-1:0] timer_count;
  logic                  timer_done;
  logic                  sample_strobe;
  logic                  sample_hi;

  // scope pins, plain wires
  assign monitor_o[0] = adc_reset_no;
  assign monitor_o[1] = adc_measure_valid_i;

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  az_phase_timer #(
    .CountWidth (CountWidth)
  ) u_timer (
    .clk     (clk),
    .reset_n (reset_n),
    .load_i  (timer_load),
    .count_i (timer_count),
    .done_o  (timer_done)
  );

  az_sequencer #(
    .CountWidth (CountWidth)
  ) u_sequencer (
    .clk                 (clk),
    .reset_n             (reset_n),
    .arm_i               (arm_i),
    .cfg_i               (cfg_i),
    .timer_done_i        (timer_done),
    .adc_measure_valid_i (adc_measure_valid_i),
    .timer_load_o        (timer_load),
    .timer_count_o       (timer_count),
    .switch_o            (switch_o),
    .adc_reset_no        (adc_reset_no),
    .status_o            (status_o),
    .sample_strobe_o     (sample_strobe),
    .sample_hi_o         (sample_hi)
  );

  // capture samples adc_data_i in the strobe cycle
  az_sample_capture u_capture (
    .clk             (clk),
    .reset_n         (reset_n),
    .sample_strobe_i (sample_strobe),
    .sample_hi_i     (sample_hi),
    .adc_data_i      (adc_data_i),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o),
    .result_diff_o   (result_diff_o)
  );

endmodule

`default_nettype wire

// ==== bench/az_assertions.sv ====
// concurrent property checks on the sequencer, attached to every az_sequencer by bind
`timescale 1ns/1ps
`default_nettype none

`include "az_switch_codes.svh"

module az_assertions (
  input wire logic               clk,
  input wire logic               reset_n,
  input wire az_pkg::az_cfg_t    cfg_i,
  input wire az_pkg::az_switch_t switch_i,
  input wire logic               adc_reset_n_i,
  input wire logic               sample_strobe_i,
  input wire logic               timer_load_i
);

  import az_pkg::*;

  // read by the bench for the closing count
  int fail_count = 0;

  // adc must never run with the hi mux while the precharge sits on boot
  assert property (@(posedge clk) disable iff (!reset_n)
    !(adc_reset_n_i && switch_i.sw_pc == `AZ_SW_PC_BOOT && switch_i.azmux == cfg_i.azmux_hi))
  else
  begin
    fail_count = fail_count + 1;
    $error("adc released with boot precharge on the hi mux");
  end

  // capture strobe is a single cycle
  assert property (@(posedge clk) disable iff (!reset_n)
    sample_strobe_i |=> !sample_strobe_i)
  else
  begin
    fail_count = fail_count + 1;
    $error("sample strobe longer than one cycle");
  end

  // one load per settle entry
  assert property (@(posedge clk) disable iff (!reset_n)
    timer_load_i |=> !timer_load_i)
  else
  begin
    fail_count = fail_count + 1;
    $error("timer load in two consecutive cycles");
  end

endmodule

bind az_sequencer az_assertions u_assertions (
  .clk             (clk),
  .reset_n         (reset_n),
  .cfg_i           (cfg_i),
  .switch_i        (switch_o),
  .adc_reset_n_i   (adc_reset_no),
  .sample_strobe_i (sample_strobe_o),
  .timer_load_i    (timer_load_o)
);

`default_nettype wire

// ==== bench/az_checker.sv ====
// bench monitor, samples the DUT ports on the falling edge and compares against the rules
`timescale 1ns/1ps
`default_nettype none

`include "az_switch_codes.svh"

module az_checker (
  input  wire logic                        clk,
  input  wire logic                        reset_n,
  input  wire logic                        arm_i,
  input  wire az_pkg::az_cfg_t             cfg_i,
  input  wire logic                        adc_valid_i,
  input  wire logic                        adc_reset_n_i,
  input  wire az_pkg::az_switch_t          switch_i,
  input  wire az_pkg::az_status_t          status_i,
  input  wire logic                        result_valid_i,
  input  wire logic signed [24:0]          result_diff_i,
  input  wire az_pkg::az_result_t          result_i,
  input  wire logic [1:0]                  monitor_i,
  // expectation for the pattern in flight
  input  wire logic [23:0]                 exp_hi_i,
  input  wire logic [23:0]                 exp_lo_i,
  input  wire logic [24:0]                 exp_diff_i,
  output int                               error_count_o,
  output int                               result_count_o
);

  import az_pkg::*;

  int         errors = 0;
  int         results = 0;
  int         cyc = 0;
  int         start_cyc = 0;
  int         step = 0;
  logic       hold_prev = 1'b0;
  logic       hold_now;
  logic       have_prev = 1'b0;
  logic       rst_prev = 1'b0;
  logic       accept_prev = 1'b0;
  logic       pending = 1'b0;
  logic       meas_hi = 1'b0;
  logic       changed;
  logic       rose;
  az_switch_t sw_prev;
  az_switch_t exp_idle;
  az_switch_t exp_sw [0:3];

  assign error_count_o  = errors;
  assign result_count_o = results;

  task automatic log_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors = errors + 1;
    $display("FAIL %s got %h expected %h", name, got, exp);
  endtask

  task automatic report_fault(input string what);
    errors = errors + 1;
    $display("ERROR %s at %0t", what, $time);
  endtask

  // idle drive, and the switch order after arming, repeats from the hi mux on boot
  always_comb
  begin
    exp_idle  = '{azmux: cfg_i.azmux_lo, sw_pc: `AZ_SW_PC_BOOT};
    exp_sw[0] = '{azmux: cfg_i.azmux_hi, sw_pc: `AZ_SW_PC_BOOT};
    exp_sw[1] = '{azmux: cfg_i.azmux_hi, sw_pc: cfg_i.sw_pc_hi};
    exp_sw[2] = '{azmux: cfg_i.azmux_hi, sw_pc: `AZ_SW_PC_BOOT};
    exp_sw[3] = '{azmux: cfg_i.azmux_lo, sw_pc: `AZ_SW_PC_BOOT};
  end

  //////////////////////////////////////////////////////////////////////
  // per cycle checks
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    cyc      = cyc + 1;
    hold_now = !reset_n || !arm_i;
    changed  = have_prev && (switch_i != sw_prev);
    rose     = !rst_prev && adc_reset_n_i;

    if (hold_prev)
    begin
      // idle outputs while reset or disarmed
      if (adc_reset_n_i)
        log_mismatch("adc_reset_no", 32'(adc_reset_n_i), 32'h0);
      if (switch_i != exp_idle)
        log_mismatch("switch_o", 32'(switch_i), 32'(exp_idle));
      if (status_i != '0)
        log_mismatch("status_o", 32'(status_i), 32'h0);
      if (result_valid_i)
        report_fault("result_valid_o pulsed while idle");
      step    = 0;
      pending = 1'b0;
    end
    else
    begin
      // settle gap from a switch change to the next action
      if ((changed || rose) && pending && (cyc - start_cyc != int'(cfg_i.precharge_count) + 2))
        log_mismatch("settle cycles", 32'(cyc - start_cyc), cfg_i.precharge_count + 2);
      if (changed)
      begin
        if (switch_i != exp_sw[step])
          log_mismatch("switch_o", 32'(switch_i), 32'(exp_sw[step]));
        step      = (step + 1) % 4;
        pending   = 1'b1;
        start_cyc = cyc;
      end
      else if (rose)
        pending = 1'b0;

      if (rose)
      begin
        meas_hi = (switch_i == exp_sw[1]);
        if (!meas_hi && switch_i != exp_sw[3])
          report_fault("adc released with the switches off a measuring setting");
      end

      if (accept_prev)
      begin
        if (adc_reset_n_i)
          report_fault("adc reset did not fall after valid");
        if (status_i.hi != meas_hi)
          log_mismatch("status_o", 32'(status_i), 32'(meas_hi));
      end
      else if (rst_prev && !adc_reset_n_i)
        report_fault("adc reset fell without valid");
    end

    if (status_i.prim_w4 || status_i.reserved)
      log_mismatch("status_o", 32'(status_i), 32'(status_i.hi));

    // scope pins mirror the adc reset and the adc valid
    if (monitor_i != {adc_valid_i, adc_reset_n_i})
      log_mismatch("monitor_o", 32'(monitor_i), 32'({adc_valid_i, adc_reset_n_i}));

    // auto-zeroed result against the pattern
    if (result_valid_i)
    begin
      results = results + 1;
      if (result_i.hi != exp_hi_i)
        log_mismatch("result_o.hi", 32'(result_i.hi), 32'(exp_hi_i));
      if (result_i.lo != exp_lo_i)
        log_mismatch("result_o.lo", 32'(result_i.lo), 32'(exp_lo_i));
      if (result_i.sign != exp_diff_i[24])
        log_mismatch("result_o.sign", 32'(result_i.sign), 32'(exp_diff_i[24]));
      if (result_diff_i != exp_diff_i)
        log_mismatch("result_diff_o", 32'(result_diff_i), 32'(exp_diff_i));
    end

    have_prev   = 1'b1;
    sw_prev     = switch_i;
    rst_prev    = adc_reset_n_i;
    accept_prev = !hold_now && adc_reset_n_i && adc_valid_i;
    hold_prev   = hold_now;
  end

endmodule

`default_nettype wire

// ==== bench/az_tb.sv ====
// bench top, clock and reset, pattern driven ADC model, watchdog and closing report
`timescale 1ns/1ps
`default_nettype none

`include "az_switch_codes.svh"

module az_tb;

  import az_pkg::*;

  localparam int NumPat = 8;

  logic                clk;
  logic                reset_n;
  logic                arm;
  az_cfg_t             cfg;
  logic                adc_valid;
  logic [AZ_ADC_W-1:0] adc_data;
  logic                adc_reset_n;
  az_switch_t          sw;
  az_status_t          status;
  logic                res_valid;
  logic signed [24:0]  res_diff;
  az_result_t          res;
  logic [1:0]          monitor;
  logic [31:0]         pat_mem [0:4*NumPat-1];
  logic [23:0]         cur_hi;
  logic [23:0]         cur_lo;
  logic [24:0]         cur_diff;
  int                  checker_errors;
  int                  result_count;

  az_acquisition_top #(
    .CountWidth (AZ_COUNT_W)
  ) dut (
    .clk                 (clk),
    .reset_n             (reset_n),
    .cfg_i               (cfg),
    .arm_i               (arm),
    .adc_measure_valid_i (adc_valid),
    .adc_data_i          (adc_data),
    .adc_reset_no        (adc_reset_n),
    .switch_o            (sw),
    .status_o            (status),
    .result_valid_o      (res_valid),
    .result_diff_o       (res_diff),
    .result_o            (res),
    .monitor_o           (monitor)
  );

  az_checker u_checker (
    .clk            (clk),
    .reset_n        (reset_n),
    .arm_i          (arm),
    .cfg_i          (cfg),
    .adc_valid_i    (adc_valid),
    .adc_reset_n_i  (adc_reset_n),
    .switch_i       (sw),
    .status_i       (status),
    .result_valid_i (res_valid),
    .result_diff_i  (res_diff),
    .result_i       (res),
    .monitor_i      (monitor),
    .exp_hi_i       (cur_hi),
    .exp_lo_i       (cur_lo),
    .exp_diff_i     (cur_diff),
    .error_count_o  (checker_errors),
    .result_count_o (result_count)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // ADC model, answers each release after a random conversion time
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rnd;
    int          delay;
    logic        is_hi;
    logic        aborted;
    rnd       = 32'ha9644a8c;
    adc_valid = 1'b0;
    adc_data  = '0;
    forever
    begin
      @(posedge clk);
      #2;
      if (adc_reset_n && !adc_valid)
      begin
        rnd     = xorshift(rnd);
        delay   = 3 + int'(rnd % 18);
        // the mux position tells which input is being converted
        is_hi   = (sw.azmux == cfg.azmux_hi);
        aborted = 1'b0;
        for (int i = 1; i < delay && !aborted; i++)
        begin
          @(posedge clk);
          #2;
          if (!adc_reset_n)
            aborted = 1'b1;
        end
        if (!aborted)
        begin
          adc_data  = is_hi ? cur_hi : cur_lo;
          adc_valid = 1'b1;
        end
      end
      else if (!adc_reset_n && adc_valid)
        adc_valid = 1'b0;
    end
  end

  // watchdog, budget scales with the longest settle count
  initial
  begin
    int max_count;
    int limit;
    #1;
    max_count = 0;
    for (int k = 0; k < NumPat; k++)
      if (int'(pat_mem[4*k+3]) > max_count)
        max_count = int'(pat_mem[4*k+3]);
    limit = NumPat * (4 * (max_count + 2) + 50) + 100;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, %0d of %0d results seen", limit, result_count, NumPat);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int seen;
    int total;
    $readmemh("bench/az_patterns.mem", pat_mem);
    reset_n  = 1'b0;
    arm      = 1'b0;
    cfg      = '{azmux_lo: `AZ_AZMUX_LO_DEF, azmux_hi: `AZ_AZMUX_HI_DEF,
                 sw_pc_hi: `AZ_SW_PC_SIGNAL, precharge_count: 24'(pat_mem[3])};
    cur_hi   = '0;
    cur_lo   = '0;
    cur_diff = '0;
    repeat (4) @(posedge clk);
    #2;
    reset_n = 1'b1;
    // disarmed idle after reset
    repeat (3) @(posedge clk);
    #2;
    for (int k = 0; k < NumPat; k++)
    begin
      cur_hi   = pat_mem[4*k][23:0];
      cur_lo   = pat_mem[4*k+1][23:0];
      cur_diff = pat_mem[4*k+2][24:0];
      // a new settle count is only taken while disarmed
      if (k == 0 || 24'(pat_mem[4*k+3]) != cfg.precharge_count)
      begin
        arm = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        cfg.precharge_count = 24'(pat_mem[4*k+3]);
        arm = 1'b1;
      end
      seen = result_count;
      while (result_count == seen)
        @(posedge clk);
      #2;
    end
    arm = 1'b0;
    repeat (10) @(posedge clk);

    total = checker_errors + dut.u_sequencer.u_assertions.fail_count;
    if (result_count != NumPat)
    begin
      $display("wrong number of results, %0d seen for %0d patterns", result_count, NumPat);
      total = total + 1;
    end
    $display("errors: checker %0d, assertions %0d, results %0d of %0d",
             checker_errors, dut.u_sequencer.u_assertions.fail_count, result_count, NumPat);
    if (total == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
src/az_pkg.sv
src/az_phase_timer.sv
src/az_sequencer.sv
src/az_sample_capture.sv
src/az_acquisition_top.sv
bench/az_assertions.sv
bench/az_checker.sv
bench/az_tb.sv

// ==== Makefile ====
# Verilator build and regression run for the auto-zero acquisition testbench

TOP := az_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f files.f -o sim_$(TOP)

# the log decides the result, a missing pass line fails the target
run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/az_patterns.mem ====
// columns: hi reading, lo reading, expected hi minus lo (25 bit two's complement),
// settle count, one auto-zero cycle per line
800100 7fff00 0000200 5
123456 012345 0111111 5
100000 100010 1fffff0 5
400000 400000 0000000 5
ffffff 000000 0ffffff 2
000000 ffffff 1000001 2
0abcde 0abcdf 1ffffff 2
7fffff 000001 07ffffe 2
